// ==== src/loader_pkg.sv ====
`default_nettype none

package loader_pkg;

	//////////////////////////////
	// Download file indices
	//////////////////////////////

	// Any index with low six bits equal to 1 is a cartridge
	localparam logic [7:0] IDX_CART     = 8'h01;
	localparam logic [7:0] IDX_CART_ALT = 8'h80;
	localparam logic [7:0] IDX_PALETTE  = 8'h03;
	localparam logic [7:0] IDX_CGB_BOOT = 8'h04;
	localparam logic [7:0] IDX_DMG_BOOT = 8'h05;
	localparam logic [7:0] IDX_SGB_BOOT = 8'h06;
	localparam logic [7:0] IDX_CHEAT    = 8'hff;

	//////////////////////////////
	// Boot ROM checksums
	//////////////////////////////

	localparam logic [17:0] CGB_CHECKSUM_MISTER   = 18'h2ce10;
	localparam logic [17:0] CGB_CHECKSUM_ORIGINAL = 18'h2f3ea;

	// Four 24-bit colours plus padding
	localparam logic [127:0] PALETTE_DEFAULT = 128'h828214517356305a5f1a3b4900000000;

	// Word address inside a 512-byte SD block
	localparam int BLOCK_ADDR_W = 8;
	localparam int BK_ADDR_W    = 17;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] dout;
		logic [7:0]  index;
	} dl_stream_t;

	// One flag per file kind, only valid while download is high
	typedef struct packed {
		logic cart;
		logic palette;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
		logic cheat;
	} dl_kind_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef struct packed {
		logic                    ack;
		logic [BLOCK_ADDR_W-1:0] buff_addr;
		logic [15:0]             buff_dout;
		logic                    buff_wr;
	} sd_rsp_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Word 7 is the top of flags, word 0 the bottom of replace
	typedef union packed {
		cheat_fields_t    fields;
		logic [7:0][15:0] words;
	} cheat_code_u;

endpackage

`default_nettype wire

// ==== src/download_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module download_decoder import loader_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire dl_stream_t dl,
	input  wire logic       bk_loading,
	output dl_kind_t        kind,
	output logic            boot_start,
	output logic            cart_done,
	output logic            core_reset
);

	logic cart_dl;
	logic boot_dl;
	logic cart_dl_q;
	logic boot_dl_q;
	logic core_reset_q;

	//////////////////////////////
	// Index decode
	//////////////////////////////

	always_comb begin
		kind.cart     = dl.download &&
			(dl.index[5:0] == IDX_CART[5:0] || dl.index == IDX_CART_ALT);
		kind.palette  = dl.download && dl.index == IDX_PALETTE;
		kind.cgb_boot = dl.download && dl.index == IDX_CGB_BOOT;
		kind.dmg_boot = dl.download && dl.index == IDX_DMG_BOOT;
		kind.sgb_boot = dl.download && dl.index == IDX_SGB_BOOT;
		kind.cheat    = dl.download && dl.index == IDX_CHEAT;
	end

	assign cart_dl = kind.cart;
	assign boot_dl = kind.cgb_boot | kind.dmg_boot | kind.sgb_boot;

	//////////////////////////////
	// Edges and core reset
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q    <= 1'b0;
			boot_dl_q    <= 1'b0;
			core_reset_q <= 1'b1;
		end else begin
			cart_dl_q    <= cart_dl;
			boot_dl_q    <= boot_dl;
			core_reset_q <= cart_dl | boot_dl | bk_loading;
		end
	end

	assign boot_start = boot_dl & ~boot_dl_q;
	assign cart_done  = cart_dl_q & ~cart_dl;

	// Loading also holds the core in its first cycle, before the register catches up
	assign core_reset = core_reset_q | bk_loading;

endmodule

`default_nettype wire

// ==== src/bootrom_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bootrom_tracker import loader_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire logic       cgb_mode,
	input  wire dl_stream_t dl,
	input  wire dl_kind_t   kind,
	input  wire logic       boot_start,
	output logic            fastboot_available,
	output logic            gba_boot_available,
	output logic            real_cgb_boot
);

	logic        custom_cgb;
	logic        custom_dmg;
	logic [17:0] checksum;
	logic        mister_cgb;

	// Sticky custom ROM flags and colour boot ROM checksum
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
			checksum   <= '0;
		end else begin
			if (kind.cgb_boot)
				custom_cgb <= 1'b1;
			if (kind.dmg_boot)
				custom_dmg <= 1'b1;

			// A new colour download restarts the sum
			if (boot_start && kind.cgb_boot)
				checksum <= '0;
			else if (kind.cgb_boot && dl.wr)
				checksum <= checksum + 18'(dl.dout[15:8]) + 18'(dl.dout[7:0]);
		end
	end

	//////////////////////////////
	// Availability
	//////////////////////////////

	assign real_cgb_boot = checksum == CGB_CHECKSUM_ORIGINAL;
	assign mister_cgb    = checksum == CGB_CHECKSUM_MISTER;

	// GBA mode needs a ROM that knows about it
	assign gba_boot_available = !custom_cgb || real_cgb_boot || mister_cgb;

	// Only the built-in style ROMs support skipping the logo
	assign fastboot_available = !((cgb_mode && custom_cgb && !mister_cgb) ||
		(!cgb_mode && custom_dmg));

endmodule

`default_nettype wire

// ==== src/aux_file_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module aux_file_capture import loader_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire dl_stream_t dl,
	input  wire dl_kind_t   kind,
	output logic [127:0]    palette,
	output cheat_code_u     cheat_code,
	output logic            cheat_valid
);

	logic       palette_wr;
	logic       cheat_wr;
	logic       cheat_last;
	logic [2:0] word_sel;

	assign palette_wr = kind.palette & dl.wr;

	//////////////////////////////
	// Cheat word decode
	//////////////////////////////

	// Only even byte addresses carry a word
	assign cheat_wr   = kind.cheat & dl.wr & ~dl.addr[0];
	assign cheat_last = cheat_wr && dl.addr[3:1] == 3'd7;

	// Field f at bits 3:2, half at bit 1
	// word index is 2*(3-f)+h
	assign word_sel = {~dl.addr[3:2], dl.addr[1]};

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette     <= PALETTE_DEFAULT;
			cheat_valid <= 1'b0;
		end else begin
			// Byte swapped so the low byte lands on top
			if (palette_wr)
				palette <= {palette[111:0], dl.dout[7:0], dl.dout[15:8]};
			cheat_valid <= cheat_last;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cheat_wr)
			cheat_code.words[word_sel] <= dl.dout;
	end

endmodule

`default_nettype wire

// ==== src/backup_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer import loader_pkg::*; (
	input  wire logic              clk_sys,
	input  wire logic              reset,
	input  wire dl_kind_t          kind,
	input  wire logic              cart_done,
	input  wire logic              img_mounted,
	input  wire logic              img_readonly,
	input  wire logic [63:0]       img_size,
	input  wire logic              has_save,
	input  wire logic              cram_wr,
	input  wire logic              load_req,
	input  wire logic              save_req,
	input  wire logic [7:0]        ram_mask,
	output sd_req_t                sd_req,
	input  wire sd_rsp_t           sd_rsp,
	output logic [15:0]            sd_buff_din,
	output logic [BK_ADDR_W-1:0]   bk_addr,
	output logic                   bk_wr,
	output logic [15:0]            bk_data,
	input  wire logic [15:0]       bk_q,
	output logic                   bk_loading,
	output logic                   backup_busy,
	output logic                   save_pending
);

	logic cart_dl_q;
	logic load_q;
	logic save_q;
	logic ack_q;
	logic bk_ena;

	logic load_rise;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic auto_start;
	logic menu_start;
	logic start_load;
	logic last_block;

	assign load_rise  = load_req & ~load_q;
	assign save_rise  = save_req & ~save_q;
	assign ack_rise   = sd_rsp.ack & ~ack_q;
	assign ack_fall   = ack_q & ~sd_rsp.ack;

	assign auto_start = cart_done & (|img_size) & bk_ena;
	assign menu_start = bk_ena & (load_rise | save_rise);
	assign start_load = auto_start | load_rise;
	assign last_block = sd_req.lba[7:0] >= ram_mask;

	//////////////////////////////
	// Backup RAM port
	//////////////////////////////

	assign bk_addr     = BK_ADDR_W'({sd_req.lba[7:0], sd_rsp.buff_addr});
	assign bk_wr       = sd_rsp.buff_wr & sd_rsp.ack;
	assign bk_data     = sd_rsp.buff_dout;
	assign sd_buff_din = bk_q;

	//////////////////////////////
	// Enable and save pending
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q    <= 1'b0;
			bk_ena       <= 1'b0;
			save_pending <= 1'b0;
		end else begin
			cart_dl_q <= kind.cart;

			// Save image is mounted by the host while the cart is loading
			if (kind.cart && !cart_dl_q)
				bk_ena <= 1'b0;
			if (kind.cart && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (backup_busy)
				save_pending <= 1'b0;
			else if (cram_wr && has_save && bk_ena)
				save_pending <= 1'b1;
		end
	end

	//////////////////////////////
	// Block walker
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			ack_q       <= 1'b0;
			sd_req      <= '0;
			backup_busy <= 1'b0;
			bk_loading  <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_req;
			ack_q  <= sd_rsp.ack;

			// Request is taken once the card answers
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			if (!backup_busy) begin
				if (auto_start || menu_start) begin
					backup_busy <= 1'b1;
					bk_loading  <= start_load;
					sd_req.lba  <= '0;
					sd_req.rd   <= start_load;
					sd_req.wr   <= ~start_load;
				end
			end else if (ack_fall) begin
				if (last_block) begin
					backup_busy <= 1'b0;
					bk_loading  <= 1'b0;
				end else begin
					// next block, same direction
					sd_req.lba <= sd_req.lba + 32'd1;
					sd_req.rd  <= bk_loading;
					sd_req.wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_top import loader_pkg::*; (
	input  wire logic            clk_sys,
	input  wire logic            reset,
	input  wire logic            cgb_mode,
	input  wire dl_stream_t      dl,
	input  wire logic            img_mounted,
	input  wire logic            img_readonly,
	input  wire logic [63:0]     img_size,
	input  wire logic            has_save,
	input  wire logic            cram_wr,
	input  wire logic            load_req,
	input  wire logic            save_req,
	input  wire logic [7:0]      ram_mask,
	output sd_req_t              sd_req,
	input  wire sd_rsp_t         sd_rsp,
	output logic [15:0]          sd_buff_din,
	output logic [BK_ADDR_W-1:0] bk_addr,
	output logic                 bk_wr,
	output logic [15:0]          bk_data,
	input  wire logic [15:0]     bk_q,
	output logic                 bk_loading,
	output logic                 backup_busy,
	output logic                 save_pending,
	output logic [127:0]         palette,
	output cheat_code_u          cheat_code,
	output logic                 cheat_valid,
	output logic                 fastboot_available,
	output logic                 gba_boot_available,
	output logic                 real_cgb_boot,
	output logic                 core_reset
);

	dl_kind_t kind;
	logic     boot_start;
	logic     cart_done;

	//////////////////////////////
	// Stream decode
	//////////////////////////////

	download_decoder u_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.bk_loading (bk_loading),
		.kind       (kind),
		.boot_start (boot_start),
		.cart_done  (cart_done),
		.core_reset (core_reset)
	);

	bootrom_tracker u_bootrom (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cgb_mode           (cgb_mode),
		.dl                 (dl),
		.kind               (kind),
		.boot_start         (boot_start),
		.fastboot_available (fastboot_available),
		.gba_boot_available (gba_boot_available),
		.real_cgb_boot      (real_cgb_boot)
	);

	aux_file_capture u_aux (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.kind        (kind),
		.palette     (palette),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	//////////////////////////////
	// Save RAM transfers
	//////////////////////////////

	backup_sequencer u_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.kind         (kind),
		.cart_done    (cart_done),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.has_save     (has_save),
		.cram_wr      (cram_wr),
		.load_req     (load_req),
		.save_req     (save_req),
		.ram_mask     (ram_mask),
		.sd_req       (sd_req),
		.sd_rsp       (sd_rsp),
		.sd_buff_din  (sd_buff_din),
		.bk_addr      (bk_addr),
		.bk_wr        (bk_wr),
		.bk_data      (bk_data),
		.bk_q         (bk_q),
		.bk_loading   (bk_loading),
		.backup_busy  (backup_busy),
		.save_pending (save_pending)
	);

endmodule

`default_nettype wire

// ==== test/loader_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_properties import loader_pkg::*; (
	input  wire logic    clk_sys,
	input  wire logic    reset,
	input  wire sd_req_t sd_req,
	input  wire logic    cheat_valid,
	input  wire logic    core_reset,
	input  wire logic    bk_loading,
	input  wire logic    backup_busy,
	input  wire logic    save_pending
);

	//////////////////////////////
	// SD request side
	//////////////////////////////

	// One direction per block
	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr))
		else $error("sd rd and wr are high in the same cycle");

	// Pending save is dropped once a transfer runs
	a_pending_clears: assert property (@(posedge clk_sys) disable iff (reset)
		backup_busy |=> !save_pending)
		else $error("save_pending still high after backup_busy");

	//////////////////////////////
	// Core side
	//////////////////////////////

	a_cheat_single: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid lasted two cycles");

	// Core stays held while loading and for the cycle after
	a_reset_on_load: assert property (@(posedge clk_sys) disable iff (reset)
		(bk_loading || $past(bk_loading)) |-> core_reset)
		else $error("core_reset low during or just after backup RAM loading");

endmodule

`default_nettype wire

// ==== test/tb_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_loader import loader_pkg::*; ();

	localparam logic [15:0] RAM_XOR = 16'h6b2d;
	localparam logic [15:0] SD_XOR  = 16'h9e37;

	// Word and block counts of the whole run, for the watchdog
	localparam int RUN_WORDS       = 8 + 8 + 760 + 64 + 64 + 16;
	localparam int RUN_BLOCKS      = 2 * 5;
	localparam int WATCHDOG_CYCLES = 2 * (RUN_WORDS + RUN_BLOCKS) * 300;

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 cgb_mode;
	dl_stream_t           dl;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [63:0]          img_size;
	logic                 has_save;
	logic                 cram_wr;
	logic                 load_req;
	logic                 save_req;
	logic [7:0]           ram_mask;
	sd_req_t              sd_req;
	sd_rsp_t              sd_rsp;
	logic [15:0]          sd_buff_din;
	logic [BK_ADDR_W-1:0] bk_addr;
	logic                 bk_wr;
	logic [15:0]          bk_data;
	logic [15:0]          bk_q;
	logic                 bk_loading;
	logic                 backup_busy;
	logic                 save_pending;
	logic [127:0]         palette;
	cheat_code_u          cheat_code;
	logic                 cheat_valid;
	logic                 fastboot_available;
	logic                 gba_boot_available;
	logic                 real_cgb_boot;
	logic                 core_reset;

	int          errors = 0;
	int          cheat_pulses = 0;
	int          load_blocks = 0;
	int          save_blocks = 0;
	logic [15:0] cheat_data [8];
	logic [15:0] rom [$];
	logic        ref_custom_cgb = 1'b0;
	logic        ref_custom_dmg = 1'b0;
	logic [17:0] ref_sum = '0;

	always #10 clk_sys = ~clk_sys;

	loader_top UUT (.*);

	bind loader_top loader_properties u_props (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sd_req       (sd_req),
		.cheat_valid  (cheat_valid),
		.core_reset   (core_reset),
		.bk_loading   (bk_loading),
		.backup_busy  (backup_busy),
		.save_pending (save_pending)
	);

	// Backup RAM model
	assign bk_q = bk_addr[15:0] ^ RAM_XOR;

	//////////////////////////////
	// Reference functions
	//////////////////////////////

	function automatic logic [127:0] palette_shift(input logic [127:0] pal, input logic [15:0] w);
		return (pal << 16) | 128'({w[7:0], w[15:8]});
	endfunction

	// Field 0 is flags, field 3 is replace; the odd word is the top half
	function automatic logic [31:0] cheat_field(input int f);
		return {cheat_data[3'(2 * f + 1)], cheat_data[3'(2 * f)]};
	endfunction

	function automatic logic [17:0] rom_checksum(input logic [15:0] words [$]);
		logic [17:0] sum;
		sum = '0;
		foreach (words[i])
			sum = sum + 18'(words[i][15:8]) + 18'(words[i][7:0]);
		return sum;
	endfunction

	// {fastboot, gba, real}
	function automatic logic [2:0] boot_flags_ref(input logic cgb, input logic cust_cgb,
		input logic cust_dmg, input logic [17:0] sum);
		logic real_boot;
		logic gba;
		logic fast;
		real_boot = sum == CGB_CHECKSUM_ORIGINAL;
		gba = !cust_cgb || real_boot || sum == CGB_CHECKSUM_MISTER;
		fast = 1'b1;
		if (cgb && cust_cgb && sum != CGB_CHECKSUM_MISTER)
			fast = 1'b0;
		if (!cgb && cust_dmg)
			fast = 1'b0;
		return {fast, gba, real_boot};
	endfunction

	function automatic logic [15:0] sd_word(input logic [7:0] blk, input logic [7:0] a);
		return {a, blk} ^ SD_XOR;
	endfunction

	function automatic logic [15:0] ram_word(input logic [7:0] blk, input logic [7:0] a);
		return {blk, a} ^ RAM_XOR;
	endfunction

	function automatic logic [7:0] pick_byte(input int remaining);
		int b;
		b = 128 + int'($urandom % 128);
		if (b > remaining)
			b = remaining;
		return 8'(b);
	endfunction

	//////////////////////////////
	// Checks and drivers
	//////////////////////////////

	task automatic check(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_boot_flags(input string name);
		logic [2:0] expected;
		expected = boot_flags_ref(cgb_mode, ref_custom_cgb, ref_custom_dmg, ref_sum);
		check(name, 128'(expected),
			128'({fastboot_available, gba_boot_available, real_cgb_boot}));
	endtask

	task automatic step_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic dl_begin(input logic [7:0] index);
		step_cycle();
		dl.download = 1'b1;
		dl.wr       = 1'b0;
		dl.addr     = '0;
		dl.dout     = '0;
		dl.index    = index;
	endtask

	task automatic dl_word(input logic [24:0] addr, input logic [15:0] data);
		step_cycle();
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.dout = data;
	endtask

	task automatic dl_end();
		step_cycle();
		dl.wr       = 1'b0;
		dl.download = 1'b0;
	endtask

	task automatic download_rom(input logic [7:0] index, input logic [15:0] words [$]);
		dl_begin(index);
		foreach (words[i])
			dl_word(25'(2 * i), words[i]);
		dl_end();
	endtask

	// Waits for a transfer to start and end, optionally checking the core reset
	task automatic run_transfer(input string name, input logic hold_reset);
		int limit;
		int n;
		limit = (int'(ram_mask) + 1) * 300;
		n = 0;
		while (!backup_busy && n < 8) begin
			step_cycle();
			n++;
		end
		if (!backup_busy) begin
			errors++;
			$display("%s: backup transfer did not start", name);
			return;
		end
		n = 0;
		while (backup_busy && n < limit) begin
			if (hold_reset)
				check({name, " core_reset"}, 128'(1), 128'(core_reset));
			step_cycle();
			n++;
		end
		if (backup_busy) begin
			errors++;
			$display("%s: backup transfer did not finish within %0d cycles", name, limit);
		end
	endtask

	//////////////////////////////
	// SD card model
	//////////////////////////////

	task automatic serve_block(input int expected_blk);
		logic       load_dir;
		logic [7:0] blk;
		int         delay;
		load_dir = sd_req.rd;
		blk = 8'(expected_blk);
		check("sd lba", 128'(expected_blk), 128'(sd_req.lba));
		delay = 1 + int'($urandom % 4);
		repeat (delay) @(posedge clk_sys);
		#2;
		sd_rsp.ack = 1'b1;
		for (int a = 0; a < 256; a++) begin
			sd_rsp.buff_addr = 8'(a);
			sd_rsp.buff_wr   = load_dir;
			sd_rsp.buff_dout = sd_word(blk, 8'(a));
			@(negedge clk_sys);
			check("bk_wr", 128'(load_dir), 128'(bk_wr));
			if (load_dir) begin
				check("bk_addr", 128'({blk, 8'(a)}), 128'(bk_addr));
				check("bk_data", 128'(sd_word(blk, 8'(a))), 128'(bk_data));
			end else begin
				check("sd_buff_din", 128'(ram_word(blk, 8'(a))), 128'(sd_buff_din));
			end
			step_cycle();
		end
		sd_rsp = '0;
		if (load_dir)
			load_blocks++;
		else
			save_blocks++;
	endtask

	initial begin : sd_model
		int blocks_in_xfer;
		sd_rsp = '0;
		blocks_in_xfer = 0;
		forever begin
			step_cycle();
			if (!backup_busy) begin
				blocks_in_xfer = 0;
			end else if (sd_req.rd || sd_req.wr) begin
				serve_block(blocks_in_xfer);
				blocks_in_xfer++;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_valid)
			cheat_pulses++;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin : main_seq
		logic [127:0] exp_pal;
		logic [15:0]  w;
		logic [3:0]   order [7];
		logic [3:0]   tmp;
		logic [7:0]   hi;
		logic [7:0]   lo;
		int           j;
		int           remaining;
		int           base;

		void'($urandom(32));
		reset        = 1'b1;
		cgb_mode     = 1'b0;
		dl           = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		has_save     = 1'b0;
		cram_wr      = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		ram_mask     = '0;

		repeat (16) @(posedge clk_sys);
		#2;
		check("reset core_reset", 128'(1), 128'(core_reset));
		check("reset sd rd wr", 128'(0), 128'({sd_req.rd, sd_req.wr}));
		check("reset busy", 128'(0), 128'({backup_busy, save_pending, cheat_valid}));
		reset = 1'b0;

		// Palette
		check("palette default", PALETTE_DEFAULT, palette);
		exp_pal = PALETTE_DEFAULT;
		dl_begin(IDX_PALETTE);
		for (int i = 0; i < 8; i++) begin
			w = 16'($urandom);
			exp_pal = palette_shift(exp_pal, w);
			dl_word(25'(2 * i), w);
		end
		dl_end();
		check("palette shift", exp_pal, palette);

		// Cheat code, address 14 always last
		for (int i = 0; i < 8; i++)
			cheat_data[3'(i)] = 16'($urandom);
		for (int i = 0; i < 7; i++)
			order[3'(i)] = 4'(2 * i);
		for (int i = 6; i > 0; i--) begin
			j = int'($urandom % 32'(i + 1));
			tmp = order[3'(i)];
			order[3'(i)] = order[3'(j)];
			order[3'(j)] = tmp;
		end
		dl_begin(IDX_CHEAT);
		for (int i = 0; i < 7; i++)
			dl_word(25'(order[3'(i)]), cheat_data[order[3'(i)][3:1]]);
		dl_word(25'd14, cheat_data[7]);
		dl_end();
		check("cheat valid", 128'(1), 128'(cheat_valid));
		check("cheat flags", 128'(cheat_field(0)), 128'(cheat_code.fields.flags));
		check("cheat address", 128'(cheat_field(1)), 128'(cheat_code.fields.address));
		check("cheat compare", 128'(cheat_field(2)), 128'(cheat_code.fields.compare));
		check("cheat replace", 128'(cheat_field(3)), 128'(cheat_code.fields.replace));
		step_cycle();
		check("cheat valid end", 128'(0), 128'(cheat_valid));
		check("cheat pulses", 128'(1), 128'(cheat_pulses));

		//////////////////////////////
		// Boot ROMs
		//////////////////////////////

		check_boot_flags("boot defaults");
		rom.delete();
		remaining = int'(CGB_CHECKSUM_ORIGINAL);
		while (remaining > 0) begin
			hi = pick_byte(remaining);
			remaining -= int'(hi);
			lo = pick_byte(remaining);
			remaining -= int'(lo);
			rom.push_back({hi, lo});
		end
		cgb_mode = 1'b1;
		download_rom(IDX_CGB_BOOT, rom);
		ref_custom_cgb = 1'b1;
		ref_sum = rom_checksum(rom);
		check("original real_cgb_boot", 128'(1), 128'(real_cgb_boot));
		check("original gba_boot", 128'(1), 128'(gba_boot_available));
		check("original fastboot", 128'(0), 128'(fastboot_available));

		rom.delete();
		for (int i = 0; i < 64; i++)
			rom.push_back(16'($urandom));
		download_rom(IDX_CGB_BOOT, rom);
		ref_sum = rom_checksum(rom);
		check_boot_flags("random cgb flags cgb mode");
		step_cycle();
		cgb_mode = 1'b0;
		#1;
		check_boot_flags("random cgb flags dmg mode");

		rom.delete();
		for (int i = 0; i < 64; i++)
			rom.push_back(16'($urandom));
		download_rom(IDX_DMG_BOOT, rom);
		ref_custom_dmg = 1'b1;
		check("dmg fastboot", 128'(0), 128'(fastboot_available));
		check_boot_flags("dmg flags");

		//////////////////////////////
		// Backup RAM transfers
		//////////////////////////////

		// Auto load after a cartridge download
		ram_mask = 8'(2 + $urandom % 3);
		img_size = 64'h8000;
		has_save = 1'b1;
		base = load_blocks;
		dl_begin(IDX_CART);
		img_mounted = 1'b1;
		for (int i = 0; i < 16; i++) begin
			dl_word(25'(2 * i), 16'($urandom));
			img_mounted = 1'b0;
		end
		dl_end();
		run_transfer("autoload", 1'b1);
		check("autoload blocks", 128'(int'(ram_mask) + 1), 128'(load_blocks - base));
		check("autoload bk_loading", 128'(0), 128'(bk_loading));

		// Save on request
		check("save_pending idle", 128'(0), 128'(save_pending));
		cram_wr = 1'b1;
		step_cycle();
		cram_wr = 1'b0;
		check("save_pending set", 128'(1), 128'(save_pending));
		base = save_blocks;
		step_cycle();
		save_req = 1'b1;
		run_transfer("save", 1'b0);
		save_req = 1'b0;
		check("save blocks", 128'(int'(ram_mask) + 1), 128'(save_blocks - base));
		check("save_pending end", 128'(0), 128'(save_pending));

		repeat (4) step_cycle();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
src/loader_pkg.sv
src/download_decoder.sv
src/bootrom_tracker.sv
src/aux_file_capture.sv
src/backup_sequencer.sv
src/loader_top.sv
test/loader_properties.sv
test/tb_loader.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_loader \
	-o tb_loader_sim

./obj_dir/tb_loader_sim | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation passed"
